// ==== hdl/forthDebug_defs.svh ====
`ifndef FORTH_DEBUG_DEFS_SVH
`define FORTH_DEBUG_DEFS_SVH

// data path and the host data word.
`define DATA_WIDTH 16

`define ADDR_WIDTH 8 // debug address and program counter.
`define MEM_DEPTH 256
`define REG_COUNT 16
`define REG_SEL_WIDTH 4 // enough to select one of REG_COUNT registers.
`define CC_WIDTH 4

// instruction layout: opcode in the low nibble, argument in the high nibble.
`define INSTR_WIDTH 8
`define ARG_WIDTH 4

`endif

// ==== hdl/forthDebugPkg.sv ====
package forthDebugPkg;

	// extended opcode, taken from instruction bits 3:1.
	typedef enum logic [2:0] {
		DEBUG_OPX_NONE    = 3'd0,
		DEBUG_OPX_RD_REG  = 3'd1,
		DEBUG_OPX_RD_CC   = 3'd2,
		DEBUG_OPX_RD_PC   = 3'd3,
		DEBUG_OPX_RD_MEM  = 3'd4,
		DEBUG_OPX_WR_MEM  = 3'd5,
		DEBUG_OPX_LD_ADDR = 3'd6
	} debugOpxT;

	typedef enum logic [1:0] {
		BUS_SEQX_NONE,
		BUS_SEQX_READ,
		BUS_SEQX_WRITE
	} busSeqxT;

	typedef enum logic [3:0] {
		REG_SEQX_NONE,
		REG_SEQX_RDB
	} regSeqxT;

	typedef enum logic [1:0] {
		CC_REGX_RUN   = 2'd0,
		CC_REGX_CLEAR = 2'd1,
		CC_REGX_SET   = 2'd2,
		CC_REGX_LOAD  = 2'd3
	} ccRegxT;

	// codes 4 to 7 are unnamed and run like PC_NEXTX_NEXT.
	typedef enum logic [2:0] {
		PC_NEXTX_NEXT = 3'd0,
		PC_NEXTX_ZERO = 3'd1,
		PC_NEXTX_ADDR = 3'd2,
		PC_NEXTX_DIN  = 3'd3
	} pcNextxT;

	typedef enum logic [1:0] {
		DEBUG_DATAX_DIN,
		DEBUG_DATAX_REGB_DATA
	} debugDataxT;

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_ACCESS, // memory read data is on its way.
		PORT_DATA
	} portStateT;

endpackage

// ==== hdl/debugDecoder.sv ====
`timescale 1ns/100ps
`include "forthDebug_defs.svh"

module debugDecoder
	import forthDebugPkg::*;
(
	input  logic [`INSTR_WIDTH-1:0] debugInstruction,

	output logic                    addrInc,
	output logic                    ldData,
	output debugDataxT              dataSel,
	output busSeqxT                 busSeqx,
	output ccRegxT                  ccRegx,
	output pcNextxT                 pcNextx,
	output regSeqxT                 regSeqx
);

	logic [`ARG_WIDTH-1:0] argField;
	logic                  incBit;
	debugOpxT              opx;

	assign argField = debugInstruction[`INSTR_WIDTH-1:`INSTR_WIDTH-`ARG_WIDTH];
	assign incBit   = debugInstruction[0];
	assign opx      = debugOpxT'(debugInstruction[3:1]);

	always_comb begin
		// idle defaults, which also cover NONE, LD_ADDR and the undefined code.
		addrInc = 1'b0;
		ldData  = 1'b0;
		dataSel = DEBUG_DATAX_DIN;
		busSeqx = BUS_SEQX_NONE;
		ccRegx  = CC_REGX_RUN;
		pcNextx = PC_NEXTX_NEXT;
		regSeqx = REG_SEQX_NONE;

		case (opx)
			DEBUG_OPX_RD_REG: begin
				regSeqx = REG_SEQX_RDB;
				dataSel = DEBUG_DATAX_REGB_DATA;
				ldData  = 1'b1;
				addrInc = incBit;
			end

			DEBUG_OPX_RD_CC: begin
				ccRegx = ccRegxT'(argField[1:0]);
			end

			DEBUG_OPX_RD_PC: begin
				pcNextx = pcNextxT'(argField[2:0]); // unnamed codes fall through as NEXT.
			end

			DEBUG_OPX_RD_MEM: begin
				busSeqx = BUS_SEQX_READ;
				ldData  = 1'b1;
				addrInc = incBit;
			end

			DEBUG_OPX_WR_MEM: begin
				busSeqx = BUS_SEQX_WRITE;
				addrInc = incBit;
			end

			default: ;
		endcase
	end

endmodule

// ==== hdl/debugPort.sv ====
`timescale 1ns/100ps
`include "forthDebug_defs.svh"

module debugPort
	import forthDebugPkg::*;
(
	input  logic                      clk,
	input  logic                      arstN,

	input  logic                      debugStrobe,
	input  logic [`INSTR_WIDTH-1:0]   debugInstruction,
	input  logic [`DATA_WIDTH-1:0]    debugDin,
	output logic [`DATA_WIDTH-1:0]    debugDout,
	output logic [`ADDR_WIDTH-1:0]    debugAddr,
	output logic                      debugBusy,
	output logic                      debugDone,

	input  logic [`DATA_WIDTH-1:0]    regRdData,
	output logic [`REG_SEL_WIDTH-1:0] regRdSel,

	input  logic [`DATA_WIDTH-1:0]    memRdData,
	output logic [`ADDR_WIDTH-1:0]    memAddr,
	output logic                      memRdEn,
	output logic                      memWrEn,
	output logic [`DATA_WIDTH-1:0]    memWrData,

	output ccRegxT                    ccCmd,
	output pcNextxT                   pcCmd,
	output logic                      cmdValid
);

	logic       addrInc;
	logic       ldData;
	debugDataxT dataSel;
	busSeqxT    busSeqx;
	ccRegxT     ccRegx;
	pcNextxT    pcNextx;
	regSeqxT    regSeqx;

	portStateT  state;
	debugOpxT   opx;
	logic       accept;
	logic       isMem;
	logic       addrIncQ; // increment and load requests held across a memory access.
	logic       ldDataQ;

	debugDecoder u_decoder (
		.debugInstruction(debugInstruction),
		.addrInc(addrInc),
		.ldData(ldData),
		.dataSel(dataSel),
		.busSeqx(busSeqx),
		.ccRegx(ccRegx),
		.pcNextx(pcNextx),
		.regSeqx(regSeqx)
	);

	assign opx       = debugOpxT'(debugInstruction[3:1]);
	assign debugBusy = (state == PORT_ACCESS);
	assign accept    = debugStrobe && !debugBusy; // strobes during a memory access are dropped.
	assign isMem     = (busSeqx != BUS_SEQX_NONE);

	// command fields only carry meaning in the cycle a strobe is accepted.
	assign cmdValid  = accept;
	assign ccCmd     = accept ? ccRegx : CC_REGX_RUN;
	assign pcCmd     = accept ? pcNextx : PC_NEXTX_NEXT;
	assign regRdSel  = (accept && regSeqx == REG_SEQX_RDB) ?
		debugInstruction[`INSTR_WIDTH-1:`INSTR_WIDTH-`ARG_WIDTH] : '0;
	assign memAddr   = debugAddr;
	assign memRdEn   = accept && (busSeqx == BUS_SEQX_READ);
	assign memWrEn   = accept && (busSeqx == BUS_SEQX_WRITE);
	assign memWrData = debugDin;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state     <= PORT_IDLE;
			debugDone <= 1'b0;
			debugDout <= '0;
			debugAddr <= '0;
			addrIncQ  <= 1'b0;
			ldDataQ   <= 1'b0;
		end else begin
			debugDone <= 1'b0;
			case (state)
				PORT_ACCESS: begin
					// the memory has registered its read data by now.
					if (ldDataQ)
						debugDout <= memRdData;
					if (addrIncQ)
						debugAddr <= debugAddr + `ADDR_WIDTH'(1);
					debugDone <= 1'b1;
					state     <= PORT_DATA;
				end

				default: begin
					state <= PORT_IDLE; // the done cycle takes new strobes like idle does.
					if (accept && isMem) begin
						addrIncQ <= addrInc;
						ldDataQ  <= ldData;
						state    <= PORT_ACCESS;
					end else if (accept) begin
						debugDone <= 1'b1;
						if (ldData)
							debugDout <= (dataSel == DEBUG_DATAX_REGB_DATA) ? regRdData : debugDin;
						if (opx == DEBUG_OPX_LD_ADDR)
							debugAddr <= debugDin[`ADDR_WIDTH-1:0];
						else if (addrInc)
							debugAddr <= debugAddr + `ADDR_WIDTH'(1);
					end
				end
			endcase
		end
	end

	strobeWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
		!(debugStrobe && debugBusy))
		else $error("debug strobe raised while the port is busy");

	// every memory access finishes with done two cycles later.
	memDoneTiming: assert property (@(posedge clk) disable iff (!arstN)
		(memRdEn || memWrEn) |-> ##2 debugDone);

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/100ps
`include "forthDebug_defs.svh"

module regFile (
	input  logic                      clk,
	input  logic                      arstN,

	input  logic                      regWrEn,
	input  logic [`REG_SEL_WIDTH-1:0] regWrSel,
	input  logic [`DATA_WIDTH-1:0]    regWrData,

	input  logic [`REG_SEL_WIDTH-1:0] regRdSel,
	output logic [`DATA_WIDTH-1:0]    regRdData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (regWrEn) begin
			regs[regWrSel] <= regWrData;
		end
	end

	// port B follows the current select, so the debug port registers it on the
	// strobe edge. A core write to the same register in that cycle is passed through.
	assign regRdData = (regWrEn && regWrSel == regRdSel) ? regWrData : regs[regRdSel];

endmodule

// ==== hdl/controlRegs.sv ====
`timescale 1ns/100ps
`include "forthDebug_defs.svh"

module controlRegs
	import forthDebugPkg::*;
(
	input  logic                   clk,
	input  logic                   arstN,

	input  logic                   step, // one-cycle pulse from the core.
	input  logic [`CC_WIDTH-1:0]   ccIn,

	input  ccRegxT                 ccCmd,
	input  pcNextxT                pcCmd,
	input  logic                   cmdValid,
	input  logic [`ADDR_WIDTH-1:0] debugAddr,
	input  logic [`DATA_WIDTH-1:0] debugDin,

	output logic [`ADDR_WIDTH-1:0] pc,
	output logic [`CC_WIDTH-1:0]   ccFlags
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (cmdValid && pcCmd == PC_NEXTX_ZERO) begin
			pc <= '0;
		end else if (cmdValid && pcCmd == PC_NEXTX_ADDR) begin
			pc <= debugAddr;
		end else if (cmdValid && pcCmd == PC_NEXTX_DIN) begin
			pc <= debugDin[`ADDR_WIDTH-1:0];
		end else if (step) begin
			pc <= pc + `ADDR_WIDTH'(1); // NEXT and the unnamed codes run here.
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ccFlags <= '0;
		end else if (cmdValid && ccCmd == CC_REGX_CLEAR) begin
			ccFlags <= '0;
		end else if (cmdValid && ccCmd == CC_REGX_SET) begin
			ccFlags <= '1;
		end else if (cmdValid && ccCmd == CC_REGX_LOAD) begin
			ccFlags <= debugDin[`CC_WIDTH-1:0];
		end else if (step) begin
			ccFlags <= ccIn;
		end
	end

	// without a step or a debug command the program counter holds.
	pcHolds: assert property (@(posedge clk) disable iff (!arstN)
		(!step && !cmdValid) |=> $stable(pc))
		else $error("pc changed without a step or a debug command");

endmodule

// ==== hdl/mainMemory.sv ====
`timescale 1ns/100ps
`include "forthDebug_defs.svh"

module mainMemory (
	input  logic                   clk,

	input  logic [`ADDR_WIDTH-1:0] memAddr,
	input  logic                   memRdEn,
	input  logic                   memWrEn,
	input  logic [`DATA_WIDTH-1:0] memWrData,
	output logic [`DATA_WIDTH-1:0] memRdData
);

	logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (memWrEn)
			mem[memAddr] <= memWrData;
	end

	// read data appears one cycle after the enable and holds until the next read.
	always_ff @(posedge clk) begin
		if (memRdEn)
			memRdData <= mem[memAddr];
	end

endmodule

// ==== hdl/forthDebugTop.sv ====
`timescale 1ns/100ps
`include "forthDebug_defs.svh"

module forthDebugTop
	import forthDebugPkg::*;
(
	input  logic                      clk,
	input  logic                      arstN,

	input  logic                      debugStrobe,
	input  logic [`INSTR_WIDTH-1:0]   debugInstruction,
	input  logic [`DATA_WIDTH-1:0]    debugDin,
	output logic [`DATA_WIDTH-1:0]    debugDout,
	output logic [`ADDR_WIDTH-1:0]    debugAddr,
	output logic                      debugBusy,
	output logic                      debugDone,

	input  logic                      regWrEn, // core side, played by the testbench.
	input  logic [`REG_SEL_WIDTH-1:0] regWrSel,
	input  logic [`DATA_WIDTH-1:0]    regWrData,
	input  logic                      step,
	input  logic [`CC_WIDTH-1:0]      ccIn,
	output logic [`ADDR_WIDTH-1:0]    pc,
	output logic [`CC_WIDTH-1:0]      ccFlags
);

	logic [`REG_SEL_WIDTH-1:0] regRdSel;
	logic [`DATA_WIDTH-1:0]    regRdData;
	logic [`ADDR_WIDTH-1:0]    memAddr;
	logic                      memRdEn;
	logic                      memWrEn;
	logic [`DATA_WIDTH-1:0]    memWrData;
	logic [`DATA_WIDTH-1:0]    memRdData;
	ccRegxT                    ccCmd;
	pcNextxT                   pcCmd;
	logic                      cmdValid;

	debugPort u_debugPort (
		.clk(clk), .arstN(arstN),
		.debugStrobe(debugStrobe), .debugInstruction(debugInstruction),
		.debugDin(debugDin), .debugDout(debugDout), .debugAddr(debugAddr),
		.debugBusy(debugBusy), .debugDone(debugDone),
		.regRdData(regRdData), .regRdSel(regRdSel),
		.memRdData(memRdData), .memAddr(memAddr), .memRdEn(memRdEn),
		.memWrEn(memWrEn), .memWrData(memWrData),
		.ccCmd(ccCmd), .pcCmd(pcCmd), .cmdValid(cmdValid)
	);

	regFile u_regFile (
		.clk(clk), .arstN(arstN),
		.regWrEn(regWrEn), .regWrSel(regWrSel), .regWrData(regWrData),
		.regRdSel(regRdSel), .regRdData(regRdData)
	);

	controlRegs u_controlRegs (
		.clk(clk), .arstN(arstN), .step(step), .ccIn(ccIn),
		.ccCmd(ccCmd), .pcCmd(pcCmd), .cmdValid(cmdValid),
		.debugAddr(debugAddr), .debugDin(debugDin),
		.pc(pc), .ccFlags(ccFlags)
	);

	mainMemory u_mainMemory (
		.clk(clk), .memAddr(memAddr), .memRdEn(memRdEn),
		.memWrEn(memWrEn), .memWrData(memWrData), .memRdData(memRdData)
	);

endmodule

// ==== verification/forthDebugTb.sv ====
`timescale 1ns/100ps
`include "forthDebug_defs.svh"

module forthDebugTb
	import forthDebugPkg::*;
;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	localparam int DONE_LIMIT   = 8; // cycles to wait for debugDone before giving up.

	typedef struct packed {
		logic [`INSTR_WIDTH-1:0] instr;
		logic [`DATA_WIDTH-1:0]  din;
		logic                    stepPulse;
		logic [`CC_WIDTH-1:0]    ccValue;
		logic [`DATA_WIDTH-1:0]  expDout;
		logic [`ADDR_WIDTH-1:0]  expPc;
		logic [`CC_WIDTH-1:0]    expCc;
		logic [`ADDR_WIDTH-1:0]  expAddr;
		logic [1:0]              expLatency;
	} entryT;

	logic                      clk;
	logic                      arstN;
	logic                      debugStrobe;
	logic [`INSTR_WIDTH-1:0]   debugInstruction;
	logic [`DATA_WIDTH-1:0]    debugDin;
	logic [`DATA_WIDTH-1:0]    debugDout;
	logic [`ADDR_WIDTH-1:0]    debugAddr;
	logic                      debugBusy;
	logic                      debugDone;
	logic                      regWrEn;
	logic [`REG_SEL_WIDTH-1:0] regWrSel;
	logic [`DATA_WIDTH-1:0]    regWrData;
	logic                      step;
	logic [`CC_WIDTH-1:0]      ccIn;
	logic [`ADDR_WIDTH-1:0]    pc;
	logic [`CC_WIDTH-1:0]      ccFlags;

	entryT stimTable[$];
	bit    tableReady = 1'b0;
	int    seed = 18121;
	int    errors = 0;
	int    checks = 0;

	// reference model state.
	logic [`DATA_WIDTH-1:0] modelMem [`MEM_DEPTH];
	logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
	logic [`ADDR_WIDTH-1:0] modelAddr;
	logic [`ADDR_WIDTH-1:0] modelPc;
	logic [`CC_WIDTH-1:0]   modelCc;
	logic [`DATA_WIDTH-1:0] modelDout;

	forthDebugTop u_dut (
		.clk(clk), .arstN(arstN),
		.debugStrobe(debugStrobe), .debugInstruction(debugInstruction),
		.debugDin(debugDin), .debugDout(debugDout), .debugAddr(debugAddr),
		.debugBusy(debugBusy), .debugDone(debugDone),
		.regWrEn(regWrEn), .regWrSel(regWrSel), .regWrData(regWrData),
		.step(step), .ccIn(ccIn), .pc(pc), .ccFlags(ccFlags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [`DATA_WIDTH-1:0] randomWord();
		return `DATA_WIDTH'($random(seed));
	endfunction

	function automatic logic [`INSTR_WIDTH-1:0] encode(logic [3:0] arg, logic [2:0] opx,
		logic inc);
		return {arg, opx, inc};
	endfunction

	task automatic checkValue(string name, logic [`DATA_WIDTH-1:0] got,
		logic [`DATA_WIDTH-1:0] exp, string tag);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: %s = %h, expected %h", tag, name, got, exp);
		end
	endtask

	// applies one debug instruction to the model and fills the expected columns.
	task automatic modelEntry(inout entryT e);
		logic [2:0] opx;
		logic       inc;
		logic [3:0] arg;
		opx = e.instr[3:1];
		inc = e.instr[0];
		arg = e.instr[7:4];

		if (opx == DEBUG_OPX_RD_PC && arg[2:0] == PC_NEXTX_ZERO)
			modelPc = '0;
		else if (opx == DEBUG_OPX_RD_PC && arg[2:0] == PC_NEXTX_ADDR)
			modelPc = modelAddr;
		else if (opx == DEBUG_OPX_RD_PC && arg[2:0] == PC_NEXTX_DIN)
			modelPc = e.din[`ADDR_WIDTH-1:0];
		else if (e.stepPulse)
			modelPc = modelPc + `ADDR_WIDTH'(1);

		if (opx == DEBUG_OPX_RD_CC && arg[1:0] == CC_REGX_CLEAR)
			modelCc = '0;
		else if (opx == DEBUG_OPX_RD_CC && arg[1:0] == CC_REGX_SET)
			modelCc = '1;
		else if (opx == DEBUG_OPX_RD_CC && arg[1:0] == CC_REGX_LOAD)
			modelCc = e.din[`CC_WIDTH-1:0];
		else if (e.stepPulse)
			modelCc = e.ccValue;

		case (opx)
			DEBUG_OPX_RD_REG: modelDout = modelRegs[arg];
			DEBUG_OPX_RD_MEM: modelDout = modelMem[modelAddr];
			DEBUG_OPX_WR_MEM: modelMem[modelAddr] = e.din;
			DEBUG_OPX_LD_ADDR: modelAddr = e.din[`ADDR_WIDTH-1:0];
			default: ;
		endcase
		if (inc && (opx == DEBUG_OPX_RD_REG || opx == DEBUG_OPX_RD_MEM || opx == DEBUG_OPX_WR_MEM))
			modelAddr = modelAddr + `ADDR_WIDTH'(1);

		e.expDout    = modelDout;
		e.expPc      = modelPc;
		e.expCc      = modelCc;
		e.expAddr    = modelAddr;
		e.expLatency = (opx == DEBUG_OPX_RD_MEM || opx == DEBUG_OPX_WR_MEM) ? 2'd2 : 2'd1;
	endtask

	task automatic addEntry(logic [`INSTR_WIDTH-1:0] instr, logic [`DATA_WIDTH-1:0] din,
		logic stepPulse, logic [`CC_WIDTH-1:0] ccValue);
		entryT e;
		e = '0;
		e.instr     = instr;
		e.din       = din;
		e.stepPulse = stepPulse;
		e.ccValue   = ccValue;
		modelEntry(e);
		stimTable.push_back(e);
	endtask

	task automatic buildTable();
		for (int r = 0; r < `REG_COUNT; r++)
			modelRegs[r] = randomWord();
		modelAddr = '0;
		modelPc   = '0;
		modelCc   = '0;
		modelDout = '0;

		// memory writes and reads, with and without auto-increment, then a wrap.
		addEntry(encode(4'h0, DEBUG_OPX_LD_ADDR, 1'b0), 16'h0040, 1'b0, 4'h0);
		for (int i = 0; i < 3; i++)
			addEntry(encode(4'h0, DEBUG_OPX_WR_MEM, 1'b1), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_WR_MEM, 1'b0), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_WR_MEM, 1'b1), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_LD_ADDR, 1'b0), 16'h0040, 1'b0, 4'h0);
		for (int i = 0; i < 3; i++)
			addEntry(encode(4'h0, DEBUG_OPX_RD_MEM, 1'b1), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_RD_MEM, 1'b0), randomWord(), 1'b1, 4'h5);
		addEntry(encode(4'h0, DEBUG_OPX_RD_MEM, 1'b1), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_LD_ADDR, 1'b0), 16'h00FF, 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_WR_MEM, 1'b1), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_LD_ADDR, 1'b0), 16'h00FF, 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_RD_MEM, 1'b1), randomWord(), 1'b0, 4'h0);

		for (int i = 0; i < `REG_COUNT; i++)
			addEntry(encode(4'(i), DEBUG_OPX_RD_REG, i[0]), randomWord(), 1'b0, 4'h0);

		addEntry(encode(4'd2, DEBUG_OPX_RD_CC, 1'b0), 16'h0000, 1'b0, 4'h0);
		addEntry(encode(4'd1, DEBUG_OPX_RD_CC, 1'b0), 16'h0000, 1'b1, 4'h9); // command beats step.
		addEntry(encode(4'd3, DEBUG_OPX_RD_CC, 1'b0), 16'h00A6, 1'b0, 4'h0);
		addEntry(encode(4'd0, DEBUG_OPX_RD_CC, 1'b0), 16'h0000, 1'b1, 4'hC);
		addEntry(encode(4'd0, DEBUG_OPX_RD_CC, 1'b0), 16'h0000, 1'b0, 4'h3);

		addEntry(encode(4'h0, DEBUG_OPX_LD_ADDR, 1'b0), 16'h005A, 1'b0, 4'h0);
		addEntry(encode(4'd1, DEBUG_OPX_RD_PC, 1'b0), 16'h0000, 1'b0, 4'h0);
		addEntry(encode(4'd2, DEBUG_OPX_RD_PC, 1'b0), 16'h0000, 1'b0, 4'h0);
		addEntry(encode(4'd3, DEBUG_OPX_RD_PC, 1'b0), 16'h1234, 1'b0, 4'h0);
		for (int code = 0; code < 8; code++)
			if (code == 0 || code >= 4)
				addEntry(encode(4'(code), DEBUG_OPX_RD_PC, 1'b0), 16'h0000, 1'b1, 4'h0);
		addEntry(encode(4'd0, DEBUG_OPX_RD_PC, 1'b0), 16'h0000, 1'b0, 4'h0);
		addEntry(encode(4'd1, DEBUG_OPX_RD_PC, 1'b0), 16'h0000, 1'b1, 4'h7);

		// undefined opcode 7 and NONE, with and without the increment bit.
		addEntry(encode(4'h0, 3'd7, 1'b0), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'hF, 3'd7, 1'b1), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'h0, DEBUG_OPX_NONE, 1'b0), randomWord(), 1'b0, 4'h0);
		addEntry(encode(4'hF, DEBUG_OPX_NONE, 1'b1), randomWord(), 1'b0, 4'h0);
	endtask

	task automatic preloadRegs();
		for (int r = 0; r < `REG_COUNT; r++) begin
			regWrEn   = 1'b1;
			regWrSel  = `REG_SEL_WIDTH'(r);
			regWrData = modelRegs[r];
			@(negedge clk);
		end
		regWrEn = 1'b0;
	endtask

	task automatic runEntry(int idx);
		entryT e;
		int    cycles;
		logic  busySeen;
		string tag;
		e   = stimTable[idx];
		tag = $sformatf("entry %0d", idx);

		debugStrobe      = 1'b1;
		debugInstruction = e.instr;
		debugDin         = e.din;
		step             = e.stepPulse;
		ccIn             = e.ccValue;
		@(negedge clk);
		debugStrobe = 1'b0;
		step        = 1'b0;
		cycles      = 1;
		busySeen    = debugBusy;
		while (!debugDone && cycles < DONE_LIMIT) begin
			@(negedge clk);
			cycles++;
			busySeen = busySeen | debugBusy;
		end

		checks++;
		assert (debugDone && cycles == int'(e.expLatency)) else begin
			errors++;
			$display("%s: debugDone did not come %0d cycles after the strobe", tag,
				e.expLatency);
		end
		checkValue("debugBusy", `DATA_WIDTH'(busySeen), `DATA_WIDTH'(e.expLatency == 2'd2), tag);
		checkValue("debugDout", debugDout, e.expDout, tag);
		checkValue("debugAddr", `DATA_WIDTH'(debugAddr), `DATA_WIDTH'(e.expAddr), tag);
		checkValue("pc", `DATA_WIDTH'(pc), `DATA_WIDTH'(e.expPc), tag);
		checkValue("ccFlags", `DATA_WIDTH'(ccFlags), `DATA_WIDTH'(e.expCc), tag);

		@(negedge clk);
		checks++;
		assert (!debugDone) else begin
			errors++;
			$display("%s: debugDone stayed high for more than one cycle", tag);
		end
	endtask

	initial begin
		arstN            = 1'b0;
		debugStrobe      = 1'b0;
		debugInstruction = '0;
		debugDin         = '0;
		regWrEn          = 1'b0;
		regWrSel         = '0;
		regWrData        = '0;
		step             = 1'b0;
		ccIn             = '0;

		buildTable();
		tableReady = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;

		checkValue("debugBusy", `DATA_WIDTH'(debugBusy), '0, "reset");
		checkValue("debugDone", `DATA_WIDTH'(debugDone), '0, "reset");
		checkValue("debugDout", debugDout, '0, "reset");
		checkValue("debugAddr", `DATA_WIDTH'(debugAddr), '0, "reset");
		checkValue("pc", `DATA_WIDTH'(pc), '0, "reset");
		checkValue("ccFlags", `DATA_WIDTH'(ccFlags), '0, "reset");

		preloadRegs();
		foreach (stimTable[i])
			runEntry(i);

		$display("%0d entries, %0d checks, %0d errors", stimTable.size(), checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// each entry takes well under ten cycles.
	initial begin
		wait (tableReady);
		repeat (stimTable.size() * 10 + RESET_CYCLES + `REG_COUNT + 4) @(posedge clk);
		$display("watchdog: the run did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/forthDebugPkg.sv
hdl/debugDecoder.sv
hdl/debugPort.sv
hdl/regFile.sv
hdl/controlRegs.sv
hdl/mainMemory.sv
hdl/forthDebugTop.sv
verification/forthDebugTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= forthDebugTb
RTL_TOP   ?= forthDebugTop
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
